/* source/posMapPkg.sv */
package posMapPkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int AddrWidth = 16;          // Program block address
    localparam int LeafWidth = 10;          // Leaf label in the ORAM tree
    localparam int LogLeavesPerBlock = 2;   // Four map entries per PLB line

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [LeafWidth-1:0] leafT;
    typedef logic [LeafWidth:0] entryT;                 // Valid bit on top of the leaf
    typedef logic [LogLeavesPerBlock-1:0] wordIdxT;

    // ========================================================================
    // Commands and controller states
    // ========================================================================
    typedef enum logic [1:0] {
        Update     = 2'd0,      // Old leaf out, fresh leaf in
        Read       = 2'd1,
        Refill     = 2'd2,      // Install a line from dataIn
        InitRefill = 2'd3       // Install a line of invalid entries
    } cmdT;

    typedef enum logic [2:0] {
        sInit,
        sIdle,
        sLookup,
        sHitWrite,
        sRefill,
        sInitRefill,
        sRespond
    } ctrlStateT;

    // Leaf source, right shifting Galois LFSR
    localparam logic [15:0] LfsrSeed = 16'hACE1;
    localparam logic [15:0] LfsrTaps = 16'hB400;    // x^16 + x^14 + x^13 + x^11 + 1

endpackage

/* source/plbBus.sv */
`timescale 1ns/10ps

interface plbBus;
    import posMapPkg::*;

    // Controller to cache
    logic    lookup;        // Tag compare and entry read
    logic    hitWrite;      // Overwrite one entry of a hitting line
    logic    refillWrite;   // One word of a line install
    logic    lineStart;     // Begin a line install
    addrT    addr;
    wordIdxT wordIdx;
    entryT   entry;

    // Cache to controller
    logic    hit;
    entryT   hitEntry;
    logic    victimValid;   // Replaced line held data
    addrT    victimAddr;    // First block address of the replaced line

    modport controller (
        output lookup, hitWrite, refillWrite, lineStart, addr, wordIdx, entry,
        input  hit, hitEntry, victimValid, victimAddr
    );

    modport cache (
        input  lookup, hitWrite, refillWrite, lineStart, addr, wordIdx, entry,
        output hit, hitEntry, victimValid, victimAddr
    );

endinterface

/* source/leafGenerator.sv */
`timescale 1ns/10ps

module leafGenerator (
    input  logic            Clock,
    input  logic            reset,
    input  logic            advance,
    output posMapPkg::leafT leaf
);
    import posMapPkg::*;

    logic [$bits(LfsrSeed)-1:0] lfsrState;

    always_ff @(posedge Clock) begin
        if (reset) begin
            lfsrState <= LfsrSeed;
        end else if (advance) begin
            // Shift right, fold the taps back in when a one drops out
            if (lfsrState[0])
                lfsrState <= (lfsrState >> 1) ^ LfsrTaps;
            else
                lfsrState <= lfsrState >> 1;
        end
    end

    assign leaf = lfsrState[LeafWidth-1:0];   // Low bits form the fresh leaf

endmodule

/* source/sweepCounter.sv */
`timescale 1ns/10ps

module sweepCounter #(
    parameter int Width = 2
) (
    input  logic             Clock,
    input  logic             reset,
    input  logic             clear,
    input  logic             step,
    output logic [Width-1:0] count,
    output logic             atEnd
);

    always_ff @(posedge Clock) begin
        if (reset || clear)
            count <= '0;
        else if (step)
            count <= count + 1'b1;      // Wraps to zero after the top
    end

    assign atEnd = &count;

endmodule

/* source/posMapRam.sv */
`timescale 1ns/10ps

module posMapRam #(
    parameter int PosMapEntries = 64
) (
    input  logic                             Clock,
    input  logic                             enable,
    input  logic                             write,
    input  logic [$clog2(PosMapEntries)-1:0] address,
    input  posMapPkg::entryT                 dataIn,
    output posMapPkg::entryT                 dataOut
);
    import posMapPkg::*;

    entryT mem [PosMapEntries];

    // Single port, read before write
    always_ff @(posedge Clock) begin
        if (enable) begin
            if (write)
                mem[address] <= dataIn;
            dataOut <= mem[address];    // Old contents come back on a write
        end
    end

endmodule

/* source/plbCache.sv */
`timescale 1ns/10ps

module plbCache #(
    parameter int PlbLines = 8
) (
    input  logic             Clock,
    input  logic             reset,
    plbBus.cache             bus,
    output logic             evictDataValid,
    output posMapPkg::entryT evictData
);
    import posMapPkg::*;

    localparam int LineIdxWidth = $clog2(PlbLines);
    localparam int TagWidth = AddrWidth - LogLeavesPerBlock - LineIdxWidth;
    localparam int SlotWidth = LineIdxWidth + LogLeavesPerBlock;

    // ========================================================================
    // Storage
    // ========================================================================
    logic [PlbLines-1:0] lineValid;
    logic [TagWidth-1:0] tagArray [PlbLines];
    entryT               entries [PlbLines << LogLeavesPerBlock];   // Indexed {line, word}

    logic [LineIdxWidth-1:0] lineIdx;
    logic [TagWidth-1:0]     lineTag;
    logic [SlotWidth-1:0]    lookupSlot;
    logic [SlotWidth-1:0]    writeSlot;
    logic                    lastWord;
    logic                    tagMatch;

    // Line index is the block number modulo the line count
    assign lineIdx = bus.addr[LogLeavesPerBlock +: LineIdxWidth];
    assign lineTag = bus.addr[AddrWidth-1 -: TagWidth];
    assign lookupSlot = {lineIdx, bus.addr[LogLeavesPerBlock-1:0]};
    assign writeSlot = {lineIdx, bus.wordIdx};
    assign lastWord = &bus.wordIdx;
    assign tagMatch = lineValid[lineIdx] && (tagArray[lineIdx] == lineTag);

    // ========================================================================
    // Line status and handshake flags
    // ========================================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            lineValid <= '0;
            bus.hit <= 1'b0;
            bus.victimValid <= 1'b0;
            evictDataValid <= 1'b0;
        end else begin
            if (bus.lookup)
                bus.hit <= tagMatch;

            if (bus.lineStart) begin
                bus.victimValid <= lineValid[lineIdx];
                lineValid[lineIdx] <= 1'b0;     // Line is unusable until fully installed
            end else if (bus.refillWrite && lastWord) begin
                lineValid[lineIdx] <= 1'b1;
            end

            // One eviction word per install write of a valid victim
            evictDataValid <= bus.refillWrite && bus.victimValid;
        end
    end

    // ========================================================================
    // Entry, tag and victim data
    // ========================================================================
    always_ff @(posedge Clock) begin
        if (bus.lookup)
            bus.hitEntry <= entries[lookupSlot];

        if (bus.refillWrite)
            evictData <= entries[writeSlot];    // Old word leaves as the new one lands

        if (bus.hitWrite || bus.refillWrite)
            entries[writeSlot] <= bus.entry;

        if (bus.refillWrite && lastWord)
            tagArray[lineIdx] <= lineTag;

        if (bus.lineStart)
            bus.victimAddr <= {tagArray[lineIdx], lineIdx, {LogLeavesPerBlock{1'b0}}};
    end

endmodule

/* source/posMapControl.sv */
`timescale 1ns/10ps

module posMapControl #(
    parameter int PosMapEntries = 64
) (
    input  logic                             Clock,
    input  logic                             reset,
    output logic                             cmdReady,
    input  logic                             cmdValid,
    input  posMapPkg::cmdT                   cmd,
    input  posMapPkg::addrT                  addrIn,
    input  logic                             dataInValid,
    input  posMapPkg::entryT                 dataIn,
    input  logic                             outReady,
    output logic                             valid,
    output logic                             hit,
    output logic                             unInit,
    output logic                             evict,
    output posMapPkg::leafT                  oldLeaf,
    output posMapPkg::leafT                  newLeaf,
    output posMapPkg::addrT                  addrOut,
    output logic                             ramEnable,
    output logic                             ramWrite,
    output logic [$clog2(PosMapEntries)-1:0] ramAddr,
    output posMapPkg::entryT                 ramDataIn,
    input  posMapPkg::entryT                 ramDataOut,
    output logic                             initClear,
    output logic                             initStep,
    input  logic [$clog2(PosMapEntries)-1:0] initCount,
    input  logic                             initAtEnd,
    output logic                             refillClear,
    output logic                             refillStep,
    input  posMapPkg::wordIdxT               refillIndex,
    input  logic                             refillAtEnd,
    output logic                             leafAdvance,
    input  posMapPkg::leafT                  freshLeaf,
    plbBus.controller                        bus
);
    import posMapPkg::*;

    localparam int RamAddrWidth = $clog2(PosMapEntries);
    localparam addrT OnChipStart = addrT'((1 << AddrWidth) - PosMapEntries);

    ctrlStateT state;
    cmdT       cmdReg;
    addrT      addrReg;
    logic      onChipReg;
    logic      onChipIn;
    logic      accept;
    addrT      ramOffset;

    assign onChipIn = addrIn >= OnChipStart;    // Top of the address space lives on chip
    assign accept = (state == sIdle) && cmdReady && cmdValid;
    assign ramOffset = addrReg - OnChipStart;

    // ========================================================================
    // State machine
    // ========================================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= sInit;
            cmdReady <= 1'b0;
            valid <= 1'b0;
        end else begin
            case (state)
                sInit: begin
                    if (initAtEnd)
                        state <= sIdle;
                end
                sIdle: begin
                    if (accept) begin
                        cmdReady <= 1'b0;
                        if (cmd == Refill)
                            state <= sRefill;
                        else if (cmd == InitRefill)
                            state <= sInitRefill;
                        else
                            state <= sLookup;
                    end else begin
                        cmdReady <= 1'b1;   // First idle cycle after the sweep
                    end
                end
                sLookup: state <= sHitWrite;
                sHitWrite: begin
                    state <= sRespond;
                    valid <= 1'b1;
                end
                sRefill: begin
                    if (dataInValid && refillAtEnd)
                        state <= sRespond;
                end
                sInitRefill: begin
                    if (refillAtEnd)
                        state <= sRespond;
                end
                sRespond: begin
                    if (!valid) begin
                        valid <= 1'b1;          // Line install done, report the victim
                    end else if (outReady) begin
                        valid <= 1'b0;
                        cmdReady <= 1'b1;
                        state <= sIdle;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // ========================================================================
    // Command capture and response registers
    // ========================================================================
    always_ff @(posedge Clock) begin
        if (accept) begin
            cmdReg <= cmd;
            addrReg <= addrIn;
            onChipReg <= onChipIn;
        end

        if (state == sHitWrite) begin
            // Entry is back from the RAM or the PLB
            hit <= onChipReg || bus.hit;
            if (onChipReg) begin
                unInit <= !ramDataOut[LeafWidth];
                oldLeaf <= ramDataOut[LeafWidth-1:0];
            end else begin
                unInit <= bus.hit && !bus.hitEntry[LeafWidth];
                oldLeaf <= bus.hitEntry[LeafWidth-1:0];
            end
            newLeaf <= freshLeaf;
            evict <= 1'b0;
            addrOut <= addrReg;
        end else if (state == sRespond && !valid) begin
            hit <= 1'b0;
            unInit <= 1'b0;
            oldLeaf <= '0;
            newLeaf <= '0;                  // No leaf tag kept per line
            evict <= bus.victimValid;
            addrOut <= bus.victimAddr;
        end
    end

    // ========================================================================
    // Steering of RAM, counters, LFSR and PLB
    // ========================================================================
    assign initClear = state != sInit;
    assign initStep = state == sInit;
    assign refillClear = accept;
    assign refillStep = (state == sRefill && dataInValid) || state == sInitRefill;
    assign leafAdvance = valid && outReady && (cmdReg == Update);

    assign ramEnable = (state == sInit) || (state == sLookup && onChipReg);
    assign ramWrite = (state == sInit) || (state == sLookup && onChipReg && cmdReg == Update);
    assign ramAddr = (state == sInit) ? initCount : ramOffset[RamAddrWidth-1:0];
    assign ramDataIn = (state == sInit) ? '0 : {1'b1, freshLeaf};   // Sweep writes invalid

    assign bus.addr = (state == sIdle) ? addrIn : addrReg;
    assign bus.lookup = (state == sLookup) && !onChipReg;
    assign bus.hitWrite = (state == sHitWrite) && !onChipReg && (cmdReg == Update) && bus.hit;
    assign bus.refillWrite = refillStep;
    assign bus.lineStart = accept && (cmd == Refill || cmd == InitRefill);
    assign bus.wordIdx = (state == sHitWrite) ? addrReg[LogLeavesPerBlock-1:0] : refillIndex;

    always_comb begin
        if (state == sHitWrite)
            bus.entry = {1'b1, freshLeaf};
        else if (state == sRefill)
            bus.entry = dataIn;
        else
            bus.entry = '0;             // InitRefill installs invalid entries
    end

endmodule

/* source/posMapPlb.sv */
`timescale 1ns/10ps

module posMapPlb #(
    parameter int PosMapEntries = 64,
    parameter int PlbLines = 8
) (
    input  logic             Clock,
    input  logic             reset,
    output logic             cmdReady,
    input  logic             cmdValid,
    input  posMapPkg::cmdT   cmd,
    input  posMapPkg::addrT  addrIn,
    input  logic             dataInValid,
    input  posMapPkg::entryT dataIn,
    input  logic             outReady,
    output logic             valid,
    output logic             hit,
    output logic             unInit,
    output logic             evict,
    output posMapPkg::leafT  oldLeaf,
    output posMapPkg::leafT  newLeaf,
    output posMapPkg::addrT  addrOut,
    output logic             evictDataValid,
    output posMapPkg::entryT evictData
);
    import posMapPkg::*;

    localparam int RamAddrWidth = $clog2(PosMapEntries);

    logic                    ramEnable;
    logic                    ramWrite;
    logic [RamAddrWidth-1:0] ramAddr;
    entryT                   ramDataIn;
    entryT                   ramDataOut;
    logic                    initClear;
    logic                    initStep;
    logic [RamAddrWidth-1:0] initCount;
    logic                    initAtEnd;
    logic                    refillClear;
    logic                    refillStep;
    wordIdxT                 refillWord;
    logic                    refillAtEnd;
    logic                    leafAdvance;
    leafT                    freshLeaf;

    plbBus plbLink ();

    posMapControl #(.PosMapEntries(PosMapEntries)) control (
        .Clock, .reset,
        .cmdReady, .cmdValid, .cmd, .addrIn, .dataInValid, .dataIn,
        .outReady, .valid, .hit, .unInit, .evict, .oldLeaf, .newLeaf, .addrOut,
        .ramEnable, .ramWrite, .ramAddr, .ramDataIn, .ramDataOut,
        .initClear, .initStep, .initCount, .initAtEnd,
        .refillClear, .refillStep, .refillIndex(refillWord), .refillAtEnd,
        .leafAdvance, .freshLeaf,
        .bus(plbLink.controller)
    );

    posMapRam #(.PosMapEntries(PosMapEntries)) ram (
        .Clock,
        .enable(ramEnable),
        .write(ramWrite),
        .address(ramAddr),
        .dataIn(ramDataIn),
        .dataOut(ramDataOut)
    );

    plbCache #(.PlbLines(PlbLines)) cache (
        .Clock, .reset,
        .bus(plbLink.cache),
        .evictDataValid,
        .evictData
    );

    // Address sweep that clears the on-chip map
    sweepCounter #(.Width(RamAddrWidth)) initSweep (
        .Clock, .reset,
        .clear(initClear),
        .step(initStep),
        .count(initCount),
        .atEnd(initAtEnd)
    );

    sweepCounter #(.Width(LogLeavesPerBlock)) refillIndex (
        .Clock, .reset,
        .clear(refillClear),
        .step(refillStep),
        .count(refillWord),
        .atEnd(refillAtEnd)
    );

    leafGenerator leafGen (
        .Clock, .reset,
        .advance(leafAdvance),
        .leaf(freshLeaf)
    );

endmodule

/* tb/posMapPlbChecker.sv */
`timescale 1ns/10ps

module posMapPlbChecker #(
    parameter int PosMapEntries = 64,
    parameter int PlbLines = 8
) (
    input  logic             Clock,
    input  logic             reset,
    input  logic             cmdReady,
    input  logic             cmdValid,
    input  posMapPkg::cmdT   cmd,
    input  posMapPkg::addrT  addrIn,
    input  logic             dataInValid,
    input  posMapPkg::entryT dataIn,
    input  logic             outReady,
    input  logic             valid,
    input  logic             hit,
    input  logic             unInit,
    input  logic             evict,
    input  posMapPkg::leafT  oldLeaf,
    input  posMapPkg::leafT  newLeaf,
    input  posMapPkg::addrT  addrOut,
    input  logic             evictDataValid,
    input  posMapPkg::entryT evictData,
    input  logic             expHit,
    input  logic             expUnInit,
    input  logic             expEvict,
    output int               errorCount
);
    import posMapPkg::*;

    localparam int OnChipBase = 65536 - PosMapEntries;

    // ========================================================================
    // Reference model state
    // ========================================================================
    logic [10:0] mapModel [PosMapEntries];
    logic        lineLive [PlbLines];
    logic [15:0] lineBase [PlbLines];           // First block address of each line
    logic [10:0] lineWords [PlbLines][4];
    logic [15:0] lfsrModel;
    logic [10:0] evictQueue [$];                // Old words still due on evictData
    int          checkCount;
    int          readyWait;
    logic        readySeen;
    logic        inFlight;
    cmdT         flightCmd;
    logic [15:0] flightAddr;
    logic        victimLive;
    logic [15:0] victimBase;
    int          refillWords;
    logic        refilling;
    logic        heldLast;
    logic [40:0] outputsLast;
    logic [40:0] outputsNow;
    int          flightAge;                     // Edges since acceptance or the last strobe
    int          riseAge;                       // Edge after that point where valid rises
    logic        validLast;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    function automatic logic [15:0] stepLfsr(input logic [15:0] state);
        // Right shift Galois form of x^16 + x^14 + x^13 + x^11 + 1
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        return state >> 1;
    endfunction

    function automatic int lineOf(input logic [15:0] address);
        return int'(address >> 2) % PlbLines;
    endfunction

    function automatic logic onChip(input logic [15:0] address);
        return int'(address) >= OnChipBase;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic acceptCommand();
        int line;
        line = lineOf(addrIn);
        if (inFlight)
            reportFailure("a command was accepted while another was in flight");
        inFlight = 1'b1;
        flightCmd = cmd;
        flightAddr = addrIn;
        flightAge = 0;
        if (cmd == InitRefill)
            riseAge = 5;
        else if (cmd == Refill)
            riseAge = -1;                       // Known once the fourth strobe lands
        else
            riseAge = 2;
        if (cmd == Refill || cmd == InitRefill) begin
            victimLive = lineLive[line];
            victimBase = lineBase[line];
            lineLive[line] = 1'b0;
            refillWords = 0;
            refilling = (cmd == Refill);
            if (cmd == InitRefill) begin
                // Four invalid words go in without strobes
                for (int word = 0; word < 4; word++) begin
                    if (victimLive)
                        evictQueue.push_back(lineWords[line][word]);
                    lineWords[line][word] = '0;
                end
                lineLive[line] = 1'b1;
                lineBase[line] = addrIn & 16'hFFFC;
            end
        end
    endtask

    task automatic takeRefillWord();
        int line;
        line = lineOf(flightAddr);
        if (victimLive)
            evictQueue.push_back(lineWords[line][refillWords]);
        lineWords[line][refillWords] = dataIn;
        refillWords++;
        if (refillWords == 4) begin
            refilling = 1'b0;
            lineLive[line] = 1'b1;
            lineBase[line] = flightAddr & 16'hFFFC;
            flightAge = 0;
            riseAge = 1;
        end
    endtask

    task automatic checkResponse();
        int          line;
        logic        modelHit;
        logic [10:0] modelEntry;
        line = lineOf(flightAddr);
        if (!inFlight) begin
            reportFailure("a response appeared with no command in flight");
        end else if (flightCmd == Refill || flightCmd == InitRefill) begin
            compareValue("evict", expEvict, evict);
            if (victimLive)
                compareValue("addrOut", victimBase, addrOut);
            if (evictQueue.size() != 0)
                reportFailure("eviction words were missing when the refill answered");
            evictQueue.delete();
        end else begin
            if (onChip(flightAddr)) begin
                modelHit = 1'b1;
                modelEntry = mapModel[int'(flightAddr) - OnChipBase];
            end else begin
                modelHit = lineLive[line] && (lineBase[line] == (flightAddr & 16'hFFFC));
                modelEntry = lineWords[line][flightAddr[1:0]];
            end
            compareValue("hit", expHit, hit);
            compareValue("unInit", expUnInit, unInit);
            if (modelHit)
                compareValue("oldLeaf", modelEntry[9:0], oldLeaf);
            if (flightCmd == Update) begin
                compareValue("newLeaf", lfsrModel[9:0], newLeaf);
                if (modelHit && onChip(flightAddr))
                    mapModel[int'(flightAddr) - OnChipBase] = {1'b1, lfsrModel[9:0]};
                else if (modelHit)
                    lineWords[line][flightAddr[1:0]] = {1'b1, lfsrModel[9:0]};
                lfsrModel = stepLfsr(lfsrModel);    // Steps as the response is taken
            end
        end
        inFlight = 1'b0;
    endtask

    // ========================================================================
    // Port watcher
    // ========================================================================
    always @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < PosMapEntries; i++)
                mapModel[i] = '0;
            for (int i = 0; i < PlbLines; i++)
                lineLive[i] = 1'b0;
            lfsrModel = 16'hACE1;
            evictQueue.delete();
            readyWait = 0;
            readySeen = 1'b0;
            inFlight = 1'b0;
            refilling = 1'b0;
            heldLast = 1'b0;
            validLast = 1'b0;
            flightAge = 0;
            riseAge = 0;
        end else begin
            outputsNow = {cmdReady, valid, hit, unInit, evict, oldLeaf, newLeaf, addrOut};
            if (!readySeen) begin
                if (cmdReady) begin
                    readySeen = 1'b1;
                    compareValue("cycles before cmdReady", PosMapEntries + 1, readyWait);
                end else begin
                    readyWait++;
                end
            end
            if (inFlight)
                flightAge++;
            if (inFlight && valid && !validLast)
                compareValue("valid latency", riseAge, flightAge - 1);
            if (heldLast)
                compareValue("held outputs", outputsLast, outputsNow);
            if ((valid || inFlight) && cmdReady)
                reportFailure("cmdReady was high while a command was in flight");
            if (evictDataValid) begin
                if (evictQueue.size() == 0)
                    reportFailure("an eviction word appeared with none expected");
                else
                    compareValue("evictData", evictQueue.pop_front(), evictData);
            end
            if (refilling && dataInValid)
                takeRefillWord();
            if (valid && outReady)
                checkResponse();
            if (cmdReady && cmdValid)
                acceptCommand();
            heldLast = valid && !outReady;      // Outputs must not move next cycle
            outputsLast = outputsNow;
            validLast = valid;
        end
    end

    task automatic printSummary();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    endtask

endmodule

/* tb/posMapPlbTb.sv */
`timescale 1ns/10ps

module posMapPlbTb;
    import posMapPkg::*;

    localparam int PosMapEntries = 64;
    localparam int PlbLines = 8;
    localparam int NumRows = 25;
    localparam int ResetCycles = 16;
    localparam int ClockPeriod = 8;

    logic  Clock = 1'b0;
    logic  reset;
    logic  cmdReady;
    logic  cmdValid;
    cmdT   cmd;
    addrT  addrIn;
    logic  dataInValid;
    entryT dataIn;
    logic  outReady;
    logic  valid;
    logic  hit;
    logic  unInit;
    logic  evict;
    leafT  oldLeaf;
    leafT  newLeaf;
    addrT  addrOut;
    logic  evictDataValid;
    entryT evictData;
    logic  expHit;
    logic  expUnInit;
    logic  expEvict;
    int    errorCount;
    int    rowFill;
    int    seedValue;

    // Command table
    cmdT   rowCmd [NumRows];
    addrT  rowAddr [NumRows];
    logic  rowHit [NumRows];
    logic  rowUnInit [NumRows];
    logic  rowEvict [NumRows];
    logic  rowHold [NumRows];                  // Hold outReady low for three cycles

    always #(ClockPeriod / 2) Clock = ~Clock;

    posMapPlb #(.PosMapEntries(PosMapEntries), .PlbLines(PlbLines)) uut (
        .Clock, .reset, .cmdReady, .cmdValid, .cmd, .addrIn, .dataInValid, .dataIn,
        .outReady, .valid, .hit, .unInit, .evict, .oldLeaf, .newLeaf, .addrOut,
        .evictDataValid, .evictData
    );

    posMapPlbChecker #(.PosMapEntries(PosMapEntries), .PlbLines(PlbLines)) scoreboard (
        .Clock, .reset, .cmdReady, .cmdValid, .cmd, .addrIn, .dataInValid, .dataIn,
        .outReady, .valid, .hit, .unInit, .evict, .oldLeaf, .newLeaf, .addrOut,
        .evictDataValid, .evictData, .expHit, .expUnInit, .expEvict, .errorCount
    );

    task automatic addRow(input cmdT command, input addrT address, input logic expectHit,
                          input logic expectUnInit, input logic expectEvict, input logic hold);
        rowCmd[rowFill] = command;
        rowAddr[rowFill] = address;
        rowHit[rowFill] = expectHit;
        rowUnInit[rowFill] = expectUnInit;
        rowEvict[rowFill] = expectEvict;
        rowHold[rowFill] = hold;
        rowFill++;
    endtask

    task automatic sendCommand(input cmdT command, input addrT address);
        while (!cmdReady)
            @(negedge Clock);
        cmd = command;
        addrIn = address;
        cmdValid = 1'b1;
        @(negedge Clock);               // Accepted on the edge in between
        cmdValid = 1'b0;
    endtask

    task automatic supplyRefillData();
        int          strobes;
        logic [31:0] randomWord;
        strobes = 0;
        while (strobes < 4) begin
            randomWord = $urandom;
            dataInValid = (randomWord[31:30] != 2'b00);     // Gaps between strobes
            dataIn = {1'b1, randomWord[LeafWidth-1:0]};
            if (dataInValid)
                strobes++;
            @(negedge Clock);
        end
        dataInValid = 1'b0;
    endtask

    task automatic takeResponse(input logic hold);
        while (!valid)
            @(negedge Clock);
        if (hold) begin
            // A competing command must wait out the stalled response
            cmd = Read;
            addrIn = 16'hFFC0;
            cmdValid = 1'b1;
            repeat (3) @(negedge Clock);
            cmdValid = 1'b0;
        end
        outReady = 1'b1;
        @(negedge Clock);
        outReady = 1'b0;
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        seedValue = $urandom(12);
        reset = 1'b1;
        cmdValid = 1'b0;
        cmd = Read;
        addrIn = '0;
        dataInValid = 1'b0;
        dataIn = '0;
        outReady = 1'b0;
        expHit = 1'b0;
        expUnInit = 1'b0;
        expEvict = 1'b0;
        rowFill = 0;
        addRow(Read,       16'hFFC5, 1, 1, 0, 0);   // On chip, cleared by the sweep
        addRow(Update,     16'hFFC5, 1, 1, 0, 0);
        addRow(Read,       16'hFFC5, 1, 0, 0, 0);
        addRow(Update,     16'hFFFF, 1, 1, 0, 1);
        addRow(Read,       16'hFFFF, 1, 0, 0, 0);
        addRow(Read,       16'h0124, 0, 0, 0, 0);   // PLB line 1, never filled
        addRow(Update,     16'h0124, 0, 0, 0, 1);
        addRow(Read,       16'h0124, 0, 0, 0, 0);
        addRow(Refill,     16'h0124, 0, 0, 0, 0);
        addRow(Read,       16'h0124, 1, 0, 0, 0);
        addRow(Read,       16'h0125, 1, 0, 0, 0);
        addRow(Read,       16'h0126, 1, 0, 0, 0);
        addRow(Read,       16'h0127, 1, 0, 0, 0);
        addRow(Update,     16'h0126, 1, 0, 0, 1);
        addRow(Read,       16'h0126, 1, 0, 0, 0);
        addRow(Refill,     16'h0164, 0, 0, 1, 1);   // Same line, other tag
        addRow(Read,       16'h0124, 0, 0, 0, 0);
        addRow(Read,       16'h0165, 1, 0, 0, 0);
        addRow(InitRefill, 16'h0300, 0, 0, 0, 0);   // PLB line 0
        addRow(Read,       16'h0302, 1, 1, 0, 1);
        addRow(Update,     16'h0303, 1, 1, 0, 0);
        addRow(Read,       16'h0303, 1, 0, 0, 0);
        addRow(InitRefill, 16'h0320, 0, 0, 1, 1);
        addRow(Read,       16'h0320, 1, 1, 0, 0);
        addRow(Refill,     16'h0164, 0, 0, 1, 0);

        repeat (ResetCycles) @(negedge Clock);
        reset = 1'b0;

        for (int row = 0; row < NumRows; row++) begin
            expHit = rowHit[row];
            expUnInit = rowUnInit[row];
            expEvict = rowEvict[row];
            sendCommand(rowCmd[row], rowAddr[row]);
            if (rowCmd[row] == Refill)
                supplyRefillData();
            takeResponse(rowHold[row]);
        end

        repeat (4) @(negedge Clock);
        scoreboard.printSummary();
        if (errorCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog sized from the reset, the sweep and the table length
    initial begin
        #(ClockPeriod * (ResetCycles + PosMapEntries + 20 * NumRows) + 2000);
        $display("Timeout: the DUT stopped answering before the command table finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* verilog.f */
source/posMapPkg.sv
source/plbBus.sv
source/leafGenerator.sv
source/sweepCounter.sv
source/posMapRam.sv
source/plbCache.sv
source/posMapControl.sv
source/posMapPlb.sv
tb/posMapPlbChecker.sv
tb/posMapPlbTb.sv
